/* include/n64_frontend_defines.svh */
// Frontend download and backup glue: widths, index codes, offsets and save codes
`ifndef N64_FRONTEND_DEFINES_SVH
`define N64_FRONTEND_DEFINES_SVH

// Bus widths
`define IOCTL_ADDR_W  27
`define IOCTL_DATA_W  16
`define RAM_WORD_W    32
`define PIFROM_ADDR_W 10

// Download index codes, compared against ioctl_index[5:0]
`define DL_INDEX_PIFROM 6'd0
`define DL_INDEX_CART   6'd1

// Cartridge image sits 8 MiB into memory
`define CART_START 27'h0800000

// Menu save type codes
`define SAVE_TYPE_NONE      3'd0
`define SAVE_TYPE_EEPROM4K  3'd1
`define SAVE_TYPE_EEPROM16K 3'd2
`define SAVE_TYPE_SRAM32K   3'd3
`define SAVE_TYPE_SRAM96K   3'd4
`define SAVE_TYPE_FLASH     3'd5

// EEPROM size codes for the core
`define EEPROM_TYPE_NONE 2'd0
`define EEPROM_TYPE_4K   2'd1
`define EEPROM_TYPE_16K  2'd2

`endif

/* hdl/n64_frontend_pkg.sv */
// Shared data types for the console frontend download and backup logic
`include "n64_frontend_defines.svh"

package n64_frontend_pkg;

	// Host download side
	typedef logic [`IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [`IOCTL_DATA_W-1:0] ioctl_word_t;

	// Memory side
	typedef logic [`RAM_WORD_W-1:0]    ram_word_t;
	typedef logic [`PIFROM_ADDR_W-1:0] pifrom_addr_t;

	// Save type as selected in the menu
	typedef enum logic [2:0] {
		SAVE_NONE      = `SAVE_TYPE_NONE,
		SAVE_EEPROM4K  = `SAVE_TYPE_EEPROM4K,
		SAVE_EEPROM16K = `SAVE_TYPE_EEPROM16K,
		SAVE_SRAM32K   = `SAVE_TYPE_SRAM32K,
		SAVE_SRAM96K   = `SAVE_TYPE_SRAM96K,
		SAVE_FLASH     = `SAVE_TYPE_FLASH
	} save_type_e;

	// EEPROM size handed to the core
	typedef enum logic [1:0] {
		EEPROM_NONE = `EEPROM_TYPE_NONE,
		EEPROM_4K   = `EEPROM_TYPE_4K,
		EEPROM_16K  = `EEPROM_TYPE_16K
	} eeprom_type_e;

endpackage

/* hdl/download_word_packer.sv */
// Pairs two 16-bit host download writes into one 32-bit memory word
`timescale 1ns/100ps

module download_word_packer
	import n64_frontend_pkg::*;
#(
	parameter bit BYTE_SWAP = 1'b0
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        enable,
	input  logic        wr,
	input  ioctl_addr_t addr,
	input  ioctl_word_t data,
	output logic        word_valid,
	output ram_word_t   word,
	output ioctl_addr_t word_addr
);

	// Address bit 1 selects the half of the 32-bit word
	logic        first_strobe;
	logic        second_strobe;
	ioctl_word_t first_q;
	ram_word_t   packed_word;

	assign first_strobe  = enable & wr & ~addr[1];
	assign second_strobe = enable & wr & addr[1];

	// Swapped order puts each half byte-reversed, first half on top
	assign packed_word = BYTE_SWAP ?
		{first_q[7:0], first_q[15:8], data[7:0], data[15:8]} :
		{data, first_q};

	// ========================================================================
	// Valid pulse, one cycle after the second half
	// ========================================================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= second_strobe;
		end
	end

	// Payload registers
	always_ff @(posedge clk_1x) begin
		if (first_strobe) begin
			first_q   <= data;
			word_addr <= addr;
		end
		if (second_strobe) begin
			word <= packed_word;
		end
	end

endmodule

/* hdl/pifrom_loader.sv */
// Boot ROM download path: detects the download and forms swapped words
`timescale 1ns/100ps
`include "n64_frontend_defines.svh"

module pifrom_loader
	import n64_frontend_pkg::*;
(
	input  logic         clk_1x,
	input  logic         rst_n,
	input  logic         ioctl_download,
	input  logic [7:0]   ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  logic         ioctl_wr,
	input  ioctl_word_t  ioctl_dout,
	output pifrom_addr_t pifrom_wraddress,
	output ram_word_t    pifrom_wrdata,
	output logic         pifrom_wren
);

	logic        pifrom_active;
	logic        index_hi_q;
	ioctl_addr_t word_addr;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pifrom_active <= 1'b0;
		end else begin
			pifrom_active <= ioctl_download & (ioctl_index[5:0] == `DL_INDEX_PIFROM);
		end
	end

	// Index bit 6 picks the upper boot ROM bank, kept with the first half
	always_ff @(posedge clk_1x) begin
		if (pifrom_active && ioctl_wr && !ioctl_addr[1]) begin
			index_hi_q <= ioctl_index[6];
		end
	end

	assign pifrom_wraddress = {index_hi_q, word_addr[10:2]};

	download_word_packer #(
		.BYTE_SWAP (1'b1)
	) packer_i (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.enable     (pifrom_active),
		.wr         (ioctl_wr),
		.addr       (ioctl_addr),
		.data       (ioctl_dout),
		.word_valid (pifrom_wren),
		.word       (pifrom_wrdata),
		.word_addr  (word_addr)
	);

endmodule

/* hdl/cart_loader.sv */
// Cartridge download path: packs words, offsets them and holds the host off
`timescale 1ns/100ps
`include "n64_frontend_defines.svh"

module cart_loader
	import n64_frontend_pkg::*;
(
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  ioctl_addr_t ioctl_addr,
	input  logic        ioctl_wr,
	input  ioctl_word_t ioctl_dout,
	input  logic        ram_ready,
	output logic        ioctl_wait,
	output ioctl_addr_t ram_wraddr,
	output ram_word_t   ram_wrdata,
	output logic        ram_wr,
	output logic        cart_active,
	output logic        cart_loaded
);

	ioctl_addr_t word_addr;
	logic        second_half;

	// Same strobe that makes the packer raise ram_wr next cycle
	assign second_half = cart_active & ioctl_wr & ioctl_addr[1];

	// Wraps at 2^27 like the host address
	assign ram_wraddr = word_addr + `CART_START;

	// ========================================================================
	// Download detect, loaded flag and host wait
	// ========================================================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			cart_active <= 1'b0;
			cart_loaded <= 1'b0;
			ioctl_wait  <= 1'b0;
		end else begin
			cart_active <= ioctl_download & (ioctl_index[5:0] == `DL_INDEX_CART);
			if (cart_active) begin
				cart_loaded <= 1'b1;
			end
			if (cart_active) begin
				if (second_half) begin
					ioctl_wait <= 1'b1;
				end
				// Memory took the word, let the host go on
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	download_word_packer #(
		.BYTE_SWAP (1'b0)
	) packer_i (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.enable     (cart_active),
		.wr         (ioctl_wr),
		.addr       (ioctl_addr),
		.data       (ioctl_dout),
		.word_valid (ram_wr),
		.word       (ram_wrdata),
		.word_addr  (word_addr)
	);

endmodule

/* hdl/backup_control.sv */
// Backup memory triggers, image-in-use flag, EEPROM size decode and user LED
`timescale 1ns/100ps

module backup_control
	import n64_frontend_pkg::*;
(
	input  logic         clk_1x,
	input  logic         rst_n,
	input  logic         cart_active,
	input  logic         osd_status,
	input  logic         reload_req,
	input  logic         save_req,
	input  logic         autosave_off,
	input  save_type_e   save_type,
	input  logic         img_mounted,
	input  logic         img_readonly,
	input  logic [31:0]  img_size,
	input  logic         bk_pending,
	output logic         bk_load,
	output logic         bk_save,
	output logic         use_img,
	output eeprom_type_e eeprom_type,
	output logic         led_user
);

	logic osd_status_q;
	logic cart_active_q;

	// Mounting during a cartridge download reloads the backup too
	assign bk_load = reload_req | (cart_active & img_mounted);
	// Autosave when the menu opens
	assign bk_save = save_req | (osd_status & ~osd_status_q & ~autosave_off);

	assign led_user = cart_active | bk_pending;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			osd_status_q  <= 1'b0;
			cart_active_q <= 1'b0;
			use_img       <= 1'b0;
		end else begin
			osd_status_q  <= osd_status;
			cart_active_q <= cart_active;
			if (cart_active && !cart_active_q) begin
				use_img <= 1'b0;
			end
			// Later assignment so a mount wins over the clear
			if (img_mounted && (img_size != 32'd0) && !img_readonly) begin
				use_img <= 1'b1;
			end
		end
	end

	always_comb begin
		case (save_type)
			SAVE_EEPROM4K:  eeprom_type = EEPROM_4K;
			SAVE_EEPROM16K: eeprom_type = EEPROM_16K;
			default:        eeprom_type = EEPROM_NONE;
		endcase
	end

endmodule

/* hdl/n64_frontend_top.sv */
// Frontend top: boot ROM loader, cartridge loader and backup memory control
`timescale 1ns/100ps

module n64_frontend_top
	import n64_frontend_pkg::*;
(
	input  logic         clk_1x,
	input  logic         rst_n,
	// Host download
	input  logic         ioctl_download,
	input  logic [7:0]   ioctl_index,
	input  ioctl_addr_t  ioctl_addr,
	input  ioctl_word_t  ioctl_dout,
	input  logic         ioctl_wr,
	output logic         ioctl_wait,
	// Boot ROM write port
	output pifrom_addr_t pifrom_wraddress,
	output ram_word_t    pifrom_wrdata,
	output logic         pifrom_wren,
	// Cartridge memory write port
	output ioctl_addr_t  ram_wraddr,
	output ram_word_t    ram_wrdata,
	output logic         ram_wr,
	input  logic         ram_ready,
	output logic         cart_loaded,
	// Backup memory and menu
	input  logic         osd_status,
	input  logic         reload_req,
	input  logic         save_req,
	input  logic         autosave_off,
	input  save_type_e   save_type,
	input  logic         img_mounted,
	input  logic         img_readonly,
	input  logic [31:0]  img_size,
	input  logic         bk_pending,
	output logic         bk_load,
	output logic         bk_save,
	output logic         use_img,
	output eeprom_type_e eeprom_type,
	output logic         led_user
);

	logic cart_active;

	// ========================================================================
	// Download paths
	// ========================================================================
	pifrom_loader pifrom_loader_i (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.ioctl_addr       (ioctl_addr),
		.ioctl_wr         (ioctl_wr),
		.ioctl_dout       (ioctl_dout),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.pifrom_wren      (pifrom_wren)
	);

	cart_loader cart_loader_i (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.ram_ready      (ram_ready),
		.ioctl_wait     (ioctl_wait),
		.ram_wraddr     (ram_wraddr),
		.ram_wrdata     (ram_wrdata),
		.ram_wr         (ram_wr),
		.cart_active    (cart_active),
		.cart_loaded    (cart_loaded)
	);

	// ========================================================================
	// Backup memory
	// ========================================================================
	backup_control backup_control_i (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.cart_active  (cart_active),
		.osd_status   (osd_status),
		.reload_req   (reload_req),
		.save_req     (save_req),
		.autosave_off (autosave_off),
		.save_type    (save_type),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_pending   (bk_pending),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.use_img      (use_img),
		.eeprom_type  (eeprom_type),
		.led_user     (led_user)
	);

endmodule

/* verification/n64_frontend_chk.sv */
// Bound checker for the frontend: download timing, packed words and backup rules
`timescale 1ns/100ps
`include "n64_frontend_defines.svh"

module n64_frontend_chk
	import n64_frontend_pkg::*;
(
	input logic         clk_1x,
	input logic         rst_n,
	input logic         ioctl_download,
	input logic [7:0]   ioctl_index,
	input ioctl_addr_t  ioctl_addr,
	input ioctl_word_t  ioctl_dout,
	input logic         ioctl_wr,
	input logic         ioctl_wait,
	input pifrom_addr_t pifrom_wraddress,
	input ram_word_t    pifrom_wrdata,
	input logic         pifrom_wren,
	input ioctl_addr_t  ram_wraddr,
	input ram_word_t    ram_wrdata,
	input logic         ram_wr,
	input logic         ram_ready,
	input logic         cart_active,
	input logic         cart_loaded,
	input logic         osd_status,
	input logic         reload_req,
	input logic         save_req,
	input logic         autosave_off,
	input save_type_e   save_type,
	input logic         img_mounted,
	input logic         img_readonly,
	input logic [31:0]  img_size,
	input logic         bk_pending,
	input logic         bk_load,
	input logic         bk_save,
	input logic         use_img,
	input eeprom_type_e eeprom_type,
	input logic         led_user
);

	logic         pif_active;
	logic         first_index6;
	ioctl_word_t  first_data;
	ioctl_addr_t  first_addr;
	logic         pif_second;
	logic         cart_second;
	logic         mount_ok;
	eeprom_type_e eeprom_expect;
	int           assert_fails = 0;

	task automatic report_fail(input string what);
		assert_fails++;
		$error("%s", what);
	endtask

	assign pif_second    = pif_active & ioctl_wr & ioctl_addr[1];
	assign cart_second   = cart_active & ioctl_wr & ioctl_addr[1];
	assign mount_ok      = img_mounted & (img_size != 32'd0) & ~img_readonly;
	assign eeprom_expect = (save_type == SAVE_EEPROM4K) ? EEPROM_4K :
		((save_type == SAVE_EEPROM16K) ? EEPROM_16K : EEPROM_NONE);

	// Boot ROM download seen from the host side
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			pif_active <= 1'b0;
		end else begin
			pif_active <= ioctl_download & (ioctl_index[5:0] == `DL_INDEX_PIFROM);
		end
	end

	// First half of each pair, as the host sent it
	always_ff @(posedge clk_1x) begin
		if (ioctl_wr && !ioctl_addr[1]) begin
			first_data   <= ioctl_dout;
			first_addr   <= ioctl_addr;
			first_index6 <= ioctl_index[6];
		end
	end

	// ========================================================================
	// Download paths
	// ========================================================================
	reset_state_a: assert property (@(posedge clk_1x)
		!rst_n |-> !pifrom_wren && !ram_wr && !ioctl_wait && !cart_loaded && !use_img)
		else report_fail("outputs not cleared during reset");

	pif_word_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pif_second |=> pifrom_wren
		&& pifrom_wrdata == {first_data[7:0], first_data[15:8],
		$past(ioctl_dout[7:0]), $past(ioctl_dout[15:8])}
		&& pifrom_wraddress == {first_index6, first_addr[10:2]})
		else report_fail("boot ROM word, address or strobe wrong after second half");

	pif_wren_only_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pifrom_wren |-> $past(pif_second))
		else report_fail("pifrom_wren high without a boot ROM second half");

	cart_word_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cart_second |=> ram_wr && ioctl_wait
		&& ram_wrdata == {$past(ioctl_dout), first_data}
		&& ram_wraddr == first_addr + `CART_START)
		else report_fail("cartridge word, address or wait wrong after second half");

	ram_wr_only_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr |-> $past(cart_second))
		else report_fail("ram_wr high without a cartridge second half");

	wait_rise_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(ioctl_wait) |-> ram_wr)
		else report_fail("ioctl_wait rose without a memory write");

	wait_release_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		(cart_active && ioctl_wait && ram_ready) |=> !ioctl_wait)
		else report_fail("ioctl_wait still high one cycle after ram_ready");

	// Host is only let go by the memory answer or the end of the download
	wait_hold_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(ioctl_wait) |-> $past(ram_ready) || !$past(cart_active))
		else report_fail("ioctl_wait dropped before memory answered");

	wait_drop_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(ioctl_download) |-> ##2 !ioctl_wait)
		else report_fail("ioctl_wait still high two cycles after the download ended");

	cart_loaded_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		(cart_active || cart_loaded) |=> cart_loaded)
		else report_fail("cart_loaded not set or not held");

	cart_loaded_rise_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(cart_loaded) |-> $past(cart_active))
		else report_fail("cart_loaded set without a cartridge download");

	// ========================================================================
	// Backup memory
	// ========================================================================
	bk_load_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		bk_load == (reload_req || (cart_active && img_mounted)))
		else report_fail("bk_load does not match its trigger");

	bk_save_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		bk_save == (save_req || ($rose(osd_status) && !autosave_off)))
		else report_fail("bk_save does not match request or autosave edge");

	use_img_set_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		mount_ok |=> use_img)
		else report_fail("use_img not set after a writable mount");

	use_img_rise_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(use_img) |-> $past(mount_ok))
		else report_fail("use_img set without a writable, non-empty mount");

	use_img_clear_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(cart_active) && !mount_ok |=> !use_img)
		else report_fail("use_img not cleared at download start");

	eeprom_type_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		eeprom_type == eeprom_expect)
		else report_fail("eeprom_type wrong for the selected save type");

	led_user_a: assert property (@(posedge clk_1x) disable iff (!rst_n)
		led_user == (cart_active || bk_pending))
		else report_fail("led_user does not follow download or pending backup");

endmodule

bind n64_frontend_top n64_frontend_chk chk_i (.*);

/* verification/n64_frontend_tb.sv */
// Testbench for the frontend download packers, host wait and backup control
`timescale 1ns/100ps

module n64_frontend_tb
	import n64_frontend_pkg::*;
();

	localparam int PIF_PAIRS  = 16;
	localparam int CART_PAIRS = 16;
	// Reset, two boot ROM downloads, cartridge, wait drop, backup
	localparam int TEST_CYCLES = 6 + 2 * (3 + 4 * PIF_PAIRS) + 5 + 13 * CART_PAIRS + 20 + 30;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic         clk_1x;
	logic         rst_n;
	logic         ioctl_download;
	logic [7:0]   ioctl_index;
	ioctl_addr_t  ioctl_addr;
	ioctl_word_t  ioctl_dout;
	logic         ioctl_wr;
	logic         ioctl_wait;
	pifrom_addr_t pifrom_wraddress;
	ram_word_t    pifrom_wrdata;
	logic         pifrom_wren;
	ioctl_addr_t  ram_wraddr;
	ram_word_t    ram_wrdata;
	logic         ram_wr;
	logic         ram_ready;
	logic         cart_loaded;
	logic         osd_status;
	logic         reload_req;
	logic         save_req;
	logic         autosave_off;
	save_type_e   save_type;
	logic         img_mounted;
	logic         img_readonly;
	logic [31:0]  img_size;
	logic         bk_pending;
	logic         bk_load;
	logic         bk_save;
	logic         use_img;
	eeprom_type_e eeprom_type;
	logic         led_user;

	integer seed;
	int     ready_delay;
	logic   mem_stall;
	int     cycle_count = 0;
	int     tb_errors = 0;
	int     errors_seen = 0;
	int     test_count = 0;

	n64_frontend_top dut_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #10 clk_1x = ~clk_1x;
	end

	always @(posedge clk_1x) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped at cycle %0d, a handshake never completed", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	// Memory model, answers each write after 1 to 8 cycles
	initial begin
		ram_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (ram_wr) begin
				ready_delay = 1 + ($unsigned($random(seed)) % 8);
				repeat (ready_delay - 1) @(negedge clk_1x);
				// Held back while the host side is tested alone
				while (mem_stall) begin
					@(negedge clk_1x);
				end
				ram_ready = 1'b1;
				@(negedge clk_1x);
				ram_ready = 1'b0;
			end
		end
	end

	function automatic ioctl_word_t rand16();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// Word aligned, so bit 1 marks the second half
	function automatic ioctl_addr_t rand_addr();
		int r;
		r = $random(seed);
		return {r[26:2], 2'b00};
	endfunction

	task automatic host_write(input ioctl_addr_t addr, input ioctl_word_t data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
		@(negedge clk_1x);
	endtask

	task automatic send_pair(input ioctl_addr_t base);
		host_write(base, rand16());
		host_write(base | 27'd2, rand16());
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_1x);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic wait_host_release();
		while (ioctl_wait) begin
			@(negedge clk_1x);
		end
	endtask

	task automatic pulse_negedge(ref logic sig);
		sig = 1'b1;
		@(negedge clk_1x);
		sig = 1'b0;
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			tb_errors++;
			$display("error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic finish_test(input string name);
		int errors_now;
		errors_now = tb_errors + dut_i.chk_i.assert_fails;
		test_count++;
		$display("test %0d %s done, %0d errors", test_count, name, errors_now - errors_seen);
		errors_seen = errors_now;
	endtask

	initial begin
		eeprom_type_e exp_eeprom;
		int           total_errors;
		seed           = 60419;
		mem_stall      = 1'b0;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		osd_status     = 1'b0;
		reload_req     = 1'b0;
		save_req       = 1'b0;
		autosave_off   = 1'b0;
		save_type      = SAVE_NONE;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 32'd0;
		bk_pending     = 1'b0;
		repeat (5) @(negedge clk_1x);
		rst_n = 1'b1;
		@(negedge clk_1x);
		check_bit("pifrom_wren", pifrom_wren, 1'b0);
		check_bit("ram_wr", ram_wr, 1'b0);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("cart_loaded", cart_loaded, 1'b0);
		check_bit("use_img", use_img, 1'b0);
		finish_test("reset_state");

		// Lower and upper boot ROM bank
		for (int bank = 0; bank < 2; bank++) begin
			start_download(bank == 0 ? 8'd0 : 8'd64);
			for (int n = 0; n < PIF_PAIRS; n++) begin
				send_pair(rand_addr());
			end
			end_download();
		end
		finish_test("pifrom_word");

		start_download(8'd1);
		for (int n = 0; n < CART_PAIRS; n++) begin
			send_pair(rand_addr());
			wait_host_release();
		end
		end_download();
		check_bit("cart_loaded", cart_loaded, 1'b1);
		finish_test("cart_word");

		// Memory holds its answer, so the download ends under wait
		mem_stall = 1'b1;
		start_download(8'd1);
		send_pair(rand_addr());
		check_bit("ioctl_wait", ioctl_wait, 1'b1);
		ioctl_download = 1'b0;
		repeat (12) @(negedge clk_1x);
		mem_stall = 1'b0;
		repeat (2) @(negedge clk_1x);
		finish_test("wait_release");

		img_size     = 32'h0000_4000;
		img_mounted  = 1'b1;
		reload_req   = 1'b1;
		@(negedge clk_1x);
		img_mounted  = 1'b0;
		reload_req   = 1'b0;
		start_download(8'd1);
		repeat (2) @(negedge clk_1x);
		// Read-only mount mid download only reloads
		img_readonly = 1'b1;
		pulse_negedge(img_mounted);
		img_readonly = 1'b0;
		end_download();
		// Empty image is not taken for backup
		img_size = 32'd0;
		pulse_negedge(img_mounted);
		pulse_negedge(osd_status);
		autosave_off = 1'b1;
		@(negedge clk_1x);
		pulse_negedge(osd_status);
		autosave_off = 1'b0;
		pulse_negedge(save_req);
		pulse_negedge(bk_pending);
		for (int i = 0; i < 6; i++) begin
			save_type = save_type_e'(i);
			@(negedge clk_1x);
			exp_eeprom = (i == 1) ? EEPROM_4K : ((i == 2) ? EEPROM_16K : EEPROM_NONE);
			if (eeprom_type !== exp_eeprom) begin
				tb_errors++;
				$display("error at %0t ns: eeprom_type expected %0d, got %0d",
					$time, exp_eeprom, eeprom_type);
			end
		end
		repeat (2) @(negedge clk_1x);
		finish_test("backup_triggers");

		total_errors = tb_errors + dut_i.chk_i.assert_fails;
		$display("%0d tests run, %0d errors", test_count, total_errors);
		if (total_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
hdl/n64_frontend_pkg.sv
hdl/download_word_packer.sv
hdl/pifrom_loader.sv
hdl/cart_loader.sv
hdl/backup_control.sv
hdl/n64_frontend_top.sv
verification/n64_frontend_chk.sv
verification/n64_frontend_tb.sv

/* Makefile */
# Verilator flow for the frontend download and backup glue

VERILATOR ?= verilator
TOP       ?= n64_frontend_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
